// File: run.sh
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module makehint_tb -f src.f -o makehint_sim \
    && ./obj_dir/makehint_sim +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -q "All tests passed" \
    && echo "PASS" || { echo "FAIL"; exit 1; }

// File: src.f
verilog/makehint_pkg.sv
verilog/hint_index_if.sv
verilog/hint_gen.sv
verilog/hint_index_buffer.sv
verilog/makehint_ctrl.sv
verilog/makehint_top.sv
test/tb_clk_gen.sv
test/makehint_sva.sv
test/makehint_tb.sv

// File: test/makehint_sva.sv
`timescale 1ns/1ns

module makehint_sva import makehint_pkg::*; (
    input logic clk,
    input logic reset_n,
    input logic zeroize,
    input logic enable,
    input logic done,
    input logic mem_rd_en,
    input logic reg_wren,
    input logic invalid_h
);

    // Cycles from an accepted enable until done returns
    localparam int RUN_CYCLES = NUM_POLY * (READS_PER_POLY + 2) + 3;

    int fail_count;

    initial fail_count = 0;

    // ----------------------------------------
    // Idle outputs
    // ----------------------------------------

    // An idle block never writes the register window
    no_write_when_done: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> !reg_wren)
    else begin
        fail_count++;
        $error("reg_wren is high while done is high");
    end

    // Nor does it read coefficient memory
    no_read_when_done: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> !mem_rd_en)
    else begin
        fail_count++;
        $error("mem_rd_en is high while done is high");
    end

    // ----------------------------------------
    // Run framing
    // ----------------------------------------

    // First and last busy cycles, then done again; zeroize cuts a run short
    run_length: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        (done && enable) |=> !done ##(RUN_CYCLES - 1) !done ##1 done)
    else begin
        fail_count++;
        $error("done is not low for the full length of a run");
    end

    // A new run always starts with a clean flag
    invalid_cleared: assert property (@(posedge clk) disable iff (!reset_n)
        (done && enable) |=> !invalid_h)
    else begin
        fail_count++;
        $error("invalid_h is still set after enable");
    end

endmodule

// File: test/makehint_tb.sv
`timescale 1ns/1ns

module makehint_tb import makehint_pkg::*; ();

    localparam int RUN_CYCLES = NUM_POLY * (READS_PER_POLY + 2) + 3;
    localparam int MEM_DEPTH  = NUM_POLY * READS_PER_POLY;

    // Four runs of at most 531 cycles plus reset and idle gaps fit easily
    localparam int TIMEOUT_CYCLES = 3000;

    // Upper edge of the hint band, Q minus GAMMA2
    localparam logic [R_W-1:0] EDGE = DIL_Q - GAMMA2;

    logic                          clk;
    logic                          reset_n;
    logic                          zeroize;
    logic                          enable;
    logic [ADDR_W-1:0]             mem_base_addr;
    logic [ADDR_W-1:0]             dest_base_addr;
    logic [LANES-1:0][COEFF_W-1:0] r_data;
    logic [LANES-1:0]              z_data;
    logic                          mem_rd_en;
    logic [ADDR_W-1:0]             mem_rd_addr;
    logic [ADDR_W-1:0]             z_rd_addr;
    logic                          done;
    logic                          invalid_h;
    logic                          reg_wren;
    logic [31:0]                   reg_wrdata;
    logic [ADDR_W-1:0]             reg_wr_addr;

    // Coefficient memory, one address per group of four lanes
    logic [LANES-1:0][COEFF_W-1:0] r_mem [0:MEM_DEPTH-1];
    logic [LANES-1:0]              z_mem [0:MEM_DEPTH-1];

    logic [31:0] exp_data [$];
    logic [31:0] rng_state;
    bit          exp_invalid;
    bit          compare_on;
    bit          sparse_run;
    int          rd_seen;
    int          wr_seen;
    int          ref_total;
    int          total_hist [4];
    int          cycle_count;
    int          check_count;
    int          mismatch_count;
    int          other_count;

    tb_clk_gen u_clk_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    makehint_top u_makehint_top (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .enable         (enable),
        .mem_base_addr  (mem_base_addr),
        .dest_base_addr (dest_base_addr),
        .r_data         (r_data),
        .z_data         (z_data),
        .mem_rd_en      (mem_rd_en),
        .mem_rd_addr    (mem_rd_addr),
        .z_rd_addr      (z_rd_addr),
        .done           (done),
        .invalid_h      (invalid_h),
        .reg_wren       (reg_wren),
        .reg_wrdata     (reg_wrdata),
        .reg_wr_addr    (reg_wr_addr)
    );

    bind makehint_top makehint_sva u_sva (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .enable    (enable),
        .done      (done),
        .mem_rd_en (mem_rd_en),
        .reg_wren  (reg_wren),
        .invalid_h (invalid_h)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Inside the open band, or exactly on its upper edge with the z bit set
    function automatic bit hint_rule(input logic [R_W-1:0] r, input logic z);
        return ((r > GAMMA2) && (r < EDGE)) || ((r == EDGE) && z);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            mismatch_count++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string what_went_wrong);
        check_count++;
        assert (cond) else begin
            other_count++;
            $display("Check failed: %s", what_went_wrong);
        end
    endtask

    // Dense runs put roughly 100 of 256 coefficients inside the hint band
    task automatic fill_memory(input bit dense);
        logic [31:0]    v;
        logic [31:0]    w;
        logic [R_W-1:0] r;
        int             thr;
        thr = dense ? 100 : 3;
        for (int off = 0; off < MEM_DEPTH; off++) begin
            for (int lane = 0; lane < LANES; lane++) begin
                rng_state = xorshift32(rng_state);
                v = rng_state;
                rng_state = xorshift32(rng_state);
                w = rng_state;
                // The last lane group is kept hint-free so the flush holds at most three bytes
                if (off == MEM_DEPTH - 1) r = '0;
                else if (int'(v[7:0]) < thr) r = R_W'(GAMMA2 + 1 + w % (EDGE - GAMMA2 - 1));
                else if (v[7:0] == 8'd200) r = EDGE;
                else if (v[7:0] == 8'd201) r = GAMMA2;
                else if (w[31]) r = R_W'(w % (GAMMA2 + 1));
                else r = R_W'(EDGE + 1 + w % (DIL_Q - EDGE - 1));
                r_mem[off][lane] = {1'b0, r};
                z_mem[off][lane] = v[16];
            end
        end
    endtask

    // Reference packing of set-hint positions, flush word and count words
    task automatic build_expected();
        logic [7:0]  pend [$];
        logic [7:0]  counts [NUM_POLY];
        logic [31:0] word;
        int          off;
        int          total;
        total = 0;
        exp_data.delete();
        for (int p = 0; p < NUM_POLY; p++) begin
            for (int c = 0; c < NUM_COEFF; c++) begin
                off = p * READS_PER_POLY + c / LANES;
                if (hint_rule(r_mem[off][c % LANES][R_W-1:0], z_mem[off][c % LANES])) begin
                    pend.push_back(8'(c));
                    total++;
                    if (pend.size() == 4) begin
                        exp_data.push_back({pend[3], pend[2], pend[1], pend[0]});
                        pend.delete();
                    end
                end
            end
            counts[p] = (total > 255) ? 8'hff : 8'(total);
        end
        word = '0;
        foreach (pend[i]) word[i*8 +: 8] = pend[i];
        exp_data.push_back(word);
        exp_data.push_back({counts[3], counts[2], counts[1], counts[0]});
        exp_data.push_back({counts[7], counts[6], counts[5], counts[4]});
        exp_invalid = (total > OMEGA);
    endtask

    // One full run, compared write by write against the reference
    task automatic run_and_check(input bit dense, input logic [ADDR_W-1:0] mbase,
                                 input logic [ADDR_W-1:0] dbase);
        int cycles;
        fill_memory(dense);
        build_expected();
        @(posedge clk);
        mem_base_addr  <= mbase;
        dest_base_addr <= dbase;
        enable         <= 1'b1;
        sparse_run = !dense;
        compare_on = 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            if (!done) cycles++;
        end while (!done);
        compare_on = 1'b0;
        check_true(cycles == RUN_CYCLES, "run length is not 531 cycles");
        check_true(exp_data.size() == 0, "expected register writes never arrived");
        check_value("invalid_h", 32'(invalid_h), 32'(exp_invalid));
    endtask

    // Dense run cut short once invalid_h is up
    task automatic zeroize_mid_run();
        fill_memory(1'b1);
        @(posedge clk);
        enable <= 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        repeat (300) @(posedge clk);
        @(negedge clk);
        check_true(invalid_h, "invalid_h is not set before zeroize");
        check_true(!done, "run ended before zeroize was applied");
        @(posedge clk);
        zeroize <= 1'b1;
        @(posedge clk);
        zeroize <= 1'b0;
        @(negedge clk);
        check_value("done", 32'(done), 32'd1);
        check_value("reg_wren", 32'(reg_wren), 32'd0);
        check_value("invalid_h", 32'(invalid_h), 32'd0);
    endtask

    // ----------------------------------------
    // Memory model and write monitor
    // ----------------------------------------

    // One cycle of read latency
    always @(posedge clk) begin
        if (mem_rd_en) begin
            r_data <= r_mem[9'(mem_rd_addr - mem_base_addr)];
            z_data <= z_mem[9'(z_rd_addr)];
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Outputs are sampled mid-cycle where they are settled
    always @(negedge clk) begin
        if (enable && done) begin
            rd_seen   = 0;
            wr_seen   = 0;
            ref_total = 0;
            foreach (total_hist[i]) total_hist[i] = 0;
        end
        if (reset_n && compare_on) begin
            // A read's hints reach the flag four cycles later
            if (!done) begin
                check_value("invalid_h", 32'(invalid_h), 32'(total_hist[3] > OMEGA));
            end
            if (mem_rd_en) begin
                check_value("mem_rd_addr", 32'(mem_rd_addr),
                            32'(mem_base_addr + ADDR_W'(rd_seen)));
                check_value("z_rd_addr", 32'(z_rd_addr), 32'(rd_seen));
                for (int lane = 0; lane < LANES; lane++) begin
                    if (hint_rule(r_mem[rd_seen][lane][R_W-1:0], z_mem[rd_seen][lane])) begin
                        ref_total++;
                    end
                end
                rd_seen++;
            end
            for (int i = 3; i > 0; i--) total_hist[i] = total_hist[i-1];
            total_hist[0] = ref_total;
            if (reg_wren) begin
                if (exp_data.size() == 0) begin
                    check_true(1'b0, "register write beyond the expected sequence");
                end else begin
                    check_value("reg_wrdata", reg_wrdata, exp_data.pop_front());
                    check_value("reg_wr_addr", 32'(reg_wr_addr),
                                32'(dest_base_addr + ADDR_W'(wr_seen)));
                end
                wr_seen++;
            end
            if (sparse_run && invalid_h) check_true(1'b0, "invalid_h set during a sparse run");
        end
    end

    initial begin
        wait (cycle_count == TIMEOUT_CYCLES);
        $display("Timeout: simulation ran for %0d cycles without finishing", cycle_count);
        $display("Some tests failed");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        zeroize        = 1'b0;
        enable         = 1'b0;
        mem_base_addr  = '0;
        dest_base_addr = '0;
        r_data         = '0;
        z_data         = '0;
        rng_state      = 32'he79f;
        compare_on     = 1'b0;
        sparse_run     = 1'b0;
        ref_total      = 0;
        cycle_count    = 0;
        check_count    = 0;
        mismatch_count = 0;
        other_count    = 0;
        wait (reset_n === 1'b1);
        @(negedge clk);
        check_value("done", 32'(done), 32'd1);
        check_value("reg_wren", 32'(reg_wren), 32'd0);
        check_value("mem_rd_en", 32'(mem_rd_en), 32'd0);
        check_value("invalid_h", 32'(invalid_h), 32'd0);

        // Run A is sparse, run B dense enough to pass OMEGA
        run_and_check(1'b0, 15'h0100, 15'h4000);
        run_and_check(1'b1, 15'h0800, 15'h4100);

        // The flag holds through idle cycles until the next enable
        repeat (20) begin
            @(negedge clk);
            check_value("invalid_h", 32'(invalid_h), 32'd1);
        end

        zeroize_mid_run();
        run_and_check(1'b0, 15'h1a00, 15'h5000);
        repeat (5) @(posedge clk);

        $display("Checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 check_count, mismatch_count, other_count, u_makehint_top.u_sva.fail_count);
        if (mismatch_count == 0 && other_count == 0 && u_makehint_top.u_sva.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic reset_n
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;

    // Free-running 20 ns clock
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset is released on a rising edge after ten full cycles
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

// File: verilog/hint_gen.sv
`timescale 1ns/1ns

module hint_gen import makehint_pkg::*; (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize,
    input  logic           enable,
    input  logic [R_W-1:0] r,
    input  logic           z_neq,
    output logic           h
);

    logic in_band;
    logic on_edge;

    // Strictly inside (GAMMA2, Q - GAMMA2) always gives a hint
    assign in_band = (r > GAMMA2) && (r < HINT_HI);

    // Exactly on the upper edge, the z comparison decides
    assign on_edge = (r == HINT_HI) && z_neq;

    // Registered result, one cycle after the memory data
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            h <= 1'b0;
        end else if (zeroize) begin
            h <= 1'b0;
        end else if (!enable) begin
            // Lanes outside a read burst must not report hints
            h <= 1'b0;
        end else begin
            h <= in_band || on_edge;
        end
    end

endmodule

// File: verilog/hint_index_buffer.sv
`timescale 1ns/1ns

module hint_index_buffer import makehint_pkg::*; (
    input logic          clk,
    input logic          reset_n,
    input logic          zeroize,
    hint_index_if.buffer hix
);

    // Pending index bytes, oldest in byte 0
    logic [6:0][7:0] pend_q;
    logic [6:0][7:0] pend_nxt;
    logic [2:0]      cnt_q;
    logic [2:0]      cnt_nxt;

    // Hint counting
    logic [2:0]      hint_pop;
    logic [8:0]      total_sum;
    logic [7:0]      total_q;

    // ----------------------------------------
    // Output dword
    // ----------------------------------------

    // A full dword goes out as soon as four bytes are held
    // Flush forces a write even when fewer or none are held
    assign hix.word_valid = (cnt_q >= 3'd4) || hix.flush;

    // Bytes past the pending count are zero, which gives the flush padding
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            hix.word[b*8 +: 8] = (3'(b) < cnt_q) ? pend_q[b] : 8'h00;
        end
    end

    // ----------------------------------------
    // Compaction
    // ----------------------------------------
    always_comb begin
        pend_nxt = pend_q;
        cnt_nxt  = cnt_q;
        if (hix.flush) begin
            // Everything still held leaves with the flush word
            cnt_nxt = 3'd0;
        end else if (cnt_q >= 3'd4) begin
            // Drop the four bytes written this cycle and move the rest down
            pend_nxt = {32'h0, pend_q[6:4]};
            cnt_nxt  = cnt_q - 3'd4;
        end
        // Set lanes are appended in lane order behind what remains
        for (int i = 0; i < LANES; i++) begin
            if (hix.hint_valid[i]) begin
                pend_nxt[cnt_nxt] = hix.index[i];
                cnt_nxt = cnt_nxt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt_q <= 3'd0;
        end else if (zeroize) begin
            cnt_q <= 3'd0;
        end else begin
            cnt_q <= cnt_nxt;
        end
    end

    // Pending bytes, valid below cnt_q
    always_ff @(posedge clk) begin
        if (zeroize) begin
            pend_q <= '0;
        end else begin
            pend_q <= pend_nxt;
        end
    end

    // ----------------------------------------
    // Running hint count
    // ----------------------------------------
    always_comb begin
        hint_pop = 3'd0;
        for (int i = 0; i < LANES; i++) begin
            hint_pop = hint_pop + 3'(hix.hint_valid[i]);
        end
    end

    assign total_sum = {1'b0, total_q} + {6'd0, hint_pop};

    // Saturates at 255 so the count bytes never wrap
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            total_q <= 8'd0;
        end else if (zeroize || hix.start) begin
            total_q <= 8'd0;
        end else if (total_sum[8]) begin
            total_q <= 8'hff;
        end else begin
            total_q <= total_sum[7:0];
        end
    end

    assign hix.hint_total = total_q;

endmodule

// File: verilog/hint_index_if.sv
`timescale 1ns/1ns

interface hint_index_if import makehint_pkg::*; ();

    // Controller side: one bit per lane plus the lane's position in the polynomial
    logic [LANES-1:0]      hint_valid;
    logic [LANES-1:0][7:0] index;
    logic                  poly_end;
    logic                  flush;
    logic                  start;

    // Buffer side: packed index dwords and the running hint count
    logic                  word_valid;
    logic [31:0]           word;
    logic [7:0]            hint_total;

    modport ctrl (output hint_valid, index, poly_end, flush, start,
                  input word_valid, word, hint_total);

    modport buffer (input hint_valid, index, flush, start,
                    output word_valid, word, hint_total);

endinterface

// File: verilog/makehint_ctrl.sv
`timescale 1ns/1ns

module makehint_ctrl import makehint_pkg::*; (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize,
    input  logic                          enable,
    input  logic [ADDR_W-1:0]             mem_base_addr,
    input  logic [ADDR_W-1:0]             dest_base_addr,
    input  logic [LANES-1:0][COEFF_W-1:0] r_data,
    input  logic [LANES-1:0]              z_data,
    output logic                          mem_rd_en,
    output logic [ADDR_W-1:0]             mem_rd_addr,
    output logic [ADDR_W-1:0]             z_rd_addr,
    output logic                          done,
    output logic                          invalid_h,
    output logic                          reg_wren,
    output logic [31:0]                   reg_wrdata,
    output logic [ADDR_W-1:0]             reg_wr_addr,
    hint_index_if.ctrl                    hix
);

    mh_state_e                 state_q;
    mh_state_e                 state_nxt;
    logic [RD_OFF_W-1:0]       rd_off_q;
    logic                      last_rd;
    logic                      rd_d1_q;
    logic                      rd_d2_q;
    logic [7:0]                idx_q;
    logic [POLY_W-1:0]         poly_q;
    logic                      poly_end_q;
    logic [NUM_POLY-1:0][7:0]  cnt_buf_q;
    logic [ADDR_W-1:0]         wr_cnt_q;
    logic                      invalid_q;
    logic [LANES-1:0]          hint;

    // ----------------------------------------
    // Read FSM
    // ----------------------------------------
    assign last_rd = (rd_off_q[RD_IDX_W-1:0] == RD_IDX_W'(READS_PER_POLY - 1));

    always_comb begin
        state_nxt = state_q;
        unique case (state_q)
            mh_idle:     if (enable) state_nxt = mh_rd_mem;
            mh_rd_mem:   if (last_rd) state_nxt = mh_wait1;
            // Two idle cycles let the last lanes pass memory and hint_gen
            mh_wait1:    state_nxt = mh_wait2;
            mh_wait2:    state_nxt = (poly_q == POLY_W'(NUM_POLY - 1)) ? mh_flush : mh_rd_mem;
            mh_flush:    state_nxt = mh_cnt_low;
            mh_cnt_low:  state_nxt = mh_cnt_high;
            mh_cnt_high: state_nxt = mh_idle;
            default:     state_nxt = mh_idle;
        endcase
    end

    // Poly counter moves in the second wait cycle and wraps after the last one
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q  <= mh_idle;
            rd_off_q <= '0;
            poly_q   <= '0;
        end else if (zeroize) begin
            state_q  <= mh_idle;
            rd_off_q <= '0;
            poly_q   <= '0;
        end else begin
            state_q <= state_nxt;
            if (hix.start) begin
                rd_off_q <= '0;
                poly_q   <= '0;
            end else begin
                if (state_q == mh_rd_mem) rd_off_q <= rd_off_q + 1'b1;
                if (state_q == mh_wait2) poly_q <= poly_q + 1'b1;
            end
        end
    end

    assign hix.start = (state_q == mh_idle) && enable;
    assign hix.flush = (state_q == mh_flush);
    assign mem_rd_en = (state_q == mh_rd_mem);
    assign mem_rd_addr = mem_base_addr + ADDR_W'(rd_off_q);
    assign z_rd_addr = ADDR_W'(rd_off_q);
    assign done = (state_q == mh_idle);

    // ----------------------------------------
    // Lane pipeline and indices
    // ----------------------------------------

    // rd_d1 marks data on r_data, rd_d2 marks hints on the interface
    // poly_end follows wait2 so hint_total already holds the last lanes
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_d1_q    <= 1'b0;
            rd_d2_q    <= 1'b0;
            idx_q      <= 8'd0;
            poly_end_q <= 1'b0;
        end else if (zeroize) begin
            rd_d1_q    <= 1'b0;
            rd_d2_q    <= 1'b0;
            idx_q      <= 8'd0;
            poly_end_q <= 1'b0;
        end else begin
            rd_d1_q    <= mem_rd_en;
            rd_d2_q    <= rd_d1_q;
            poly_end_q <= (state_q == mh_wait2);
            // Wraps to zero at each polynomial boundary by width alone
            if (hix.start) idx_q <= 8'd0;
            else if (rd_d2_q) idx_q <= idx_q + 8'(LANES);
        end
    end

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        hint_gen u_hint_gen (
            .clk     (clk),
            .reset_n (reset_n),
            .zeroize (zeroize),
            .enable  (rd_d1_q),
            .r       (r_data[i][R_W-1:0]),
            .z_neq   (z_data[i]),
            .h       (hint[i])
        );
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            hix.index[i] = idx_q + 8'(i);
        end
    end

    assign hix.hint_valid = hint;
    assign hix.poly_end = poly_end_q;

    // ----------------------------------------
    // Counts, invalid flag and register window
    // ----------------------------------------

    // After eight shifts byte i holds the total at the end of polynomial i
    always_ff @(posedge clk) begin
        if (zeroize) cnt_buf_q <= '0;
        else if (hix.poly_end) cnt_buf_q <= {hix.hint_total, cnt_buf_q[NUM_POLY-1:1]};
    end

    // Sticky until a new run starts
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            invalid_q <= 1'b0;
        end else if (zeroize || hix.start) begin
            invalid_q <= 1'b0;
        end else if (hix.hint_total > 8'(OMEGA)) begin
            invalid_q <= 1'b1;
        end
    end

    assign invalid_h = invalid_q;

    assign reg_wren = hix.word_valid || (state_q == mh_cnt_low) || (state_q == mh_cnt_high);

    always_comb begin
        if (hix.word_valid) reg_wrdata = hix.word;
        else if (state_q == mh_cnt_high) reg_wrdata = cnt_buf_q[NUM_POLY-1:NUM_POLY/2];
        else if (state_q == mh_cnt_low) reg_wrdata = cnt_buf_q[NUM_POLY/2-1:0];
        else reg_wrdata = 32'h0;
    end

    // Write n of a run lands at dest_base_addr + n
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) wr_cnt_q <= '0;
        else if (zeroize || hix.start) wr_cnt_q <= '0;
        else if (reg_wren) wr_cnt_q <= wr_cnt_q + 1'b1;
    end

    assign reg_wr_addr = dest_base_addr + wr_cnt_q;

endmodule

// File: verilog/makehint_pkg.sv
package makehint_pkg;

    // ----------------------------------------
    // Scheme constants
    // ----------------------------------------

    // Coefficient width as held in memory
    localparam int COEFF_W = 24;

    // Width of a reduced coefficient, since the memory's top bit is always zero
    localparam int R_W = COEFF_W - 1;

    // Modulus and the low-order rounding range
    localparam logic [R_W-1:0] DIL_Q = 23'd8380417;
    localparam logic [R_W-1:0] GAMMA2 = (DIL_Q - 23'd1) / 23'd32;

    // Upper edge of the hint band, Q - GAMMA2
    localparam logic [R_W-1:0] HINT_HI = DIL_Q - GAMMA2;

    localparam int NUM_COEFF = 256;
    localparam int NUM_POLY = 8;

    // Largest legal number of set hints over all polynomials
    localparam int OMEGA = 75;

    // Memory and register window address width
    localparam int ADDR_W = 15;

    // Coefficient pairs read per cycle
    localparam int LANES = 4;

    // Read cycles per polynomial and the counter widths derived from it
    localparam int READS_PER_POLY = NUM_COEFF / LANES;
    localparam int RD_IDX_W = $clog2(READS_PER_POLY);
    localparam int RD_OFF_W = $clog2(NUM_POLY * READS_PER_POLY);
    localparam int POLY_W = $clog2(NUM_POLY);

    // ----------------------------------------
    // Controller FSM
    // ----------------------------------------
    typedef enum logic [2:0] {
        mh_idle,
        mh_rd_mem,
        mh_wait1,
        mh_wait2,
        mh_flush,
        mh_cnt_low,
        mh_cnt_high
    } mh_state_e;

endpackage

// File: verilog/makehint_top.sv
`timescale 1ns/1ns

module makehint_top import makehint_pkg::*; (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize,
    input  logic                          enable,
    input  logic [ADDR_W-1:0]             mem_base_addr,
    input  logic [ADDR_W-1:0]             dest_base_addr,
    input  logic [LANES-1:0][COEFF_W-1:0] r_data,
    input  logic [LANES-1:0]              z_data,
    output logic                          mem_rd_en,
    output logic [ADDR_W-1:0]             mem_rd_addr,
    output logic [ADDR_W-1:0]             z_rd_addr,
    output logic                          done,
    output logic                          invalid_h,
    output logic                          reg_wren,
    output logic [31:0]                   reg_wrdata,
    output logic [ADDR_W-1:0]             reg_wr_addr
);

    // Hint lanes go one way, packed dwords and the hint count come back
    hint_index_if hix ();

    // FSM, address counters, hint lanes and the register window mux
    makehint_ctrl u_ctrl (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .enable         (enable),
        .mem_base_addr  (mem_base_addr),
        .dest_base_addr (dest_base_addr),
        .r_data         (r_data),
        .z_data         (z_data),
        .mem_rd_en      (mem_rd_en),
        .mem_rd_addr    (mem_rd_addr),
        .z_rd_addr      (z_rd_addr),
        .done           (done),
        .invalid_h      (invalid_h),
        .reg_wren       (reg_wren),
        .reg_wrdata     (reg_wrdata),
        .reg_wr_addr    (reg_wr_addr),
        .hix            (hix.ctrl)
    );

    // Packs set-hint positions four per dword
    hint_index_buffer u_buf (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .hix     (hix.buffer)
    );

endmodule
